/* run_sim.sh */
#!/bin/sh
# Compile and run the trace subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_lb_trace \
   -o tb_lb_trace > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_lb_trace > sim.log 2>&1 || echo "TESTBENCH FAILED" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed"; exit 1; } || {
   echo "Simulation passed"
   exit 0
}

/* src/lb_regs.sv */
/*
 * Local-bus register block
 * Address decode, control and status registers, two-stage read
 * pipeline into lb_rdata and the status LED drive
 */
`include "lb_trace_cfg.svh"

module lb_regs (
   input  logic                       lb_clk,
   input  logic                       rst_n,
   input  logic                       lb_valid,
   input  logic                       lb_rnw,
   input  logic                       lb_renable,
   input  logic [`LB_ADDR_W-1:0]      lb_addr,
   input  logic [`LB_DATA_W-1:0]      lb_wdata,
   input  logic [`TRACE_EW-1:0]       ram_rdata,
   input  lb_trace_pkg::cap_state_e   cap_state,
   input  logic [`TRACE_AW:0]         wr_ptr,
   input  logic                       overflow,
   output logic [`LB_DATA_W-1:0]      lb_rdata,
   output logic                       ram_rd_req,
   output logic [`TRACE_AW-1:0]       ram_rd_addr,
   output logic                       rearm,
   output logic [1:0]                 led
);

   logic [`RAM_SEL_BIT-1:0]   reg_addr;
   logic                      ram_hit;
   logic                      ctrl_hit;
   logic                      stat_hit;
   logic                      ctrl_wr;
   logic                      led_en;
   lb_trace_pkg::reg_sel_e    rd_sel;
   lb_trace_pkg::reg_sel_e    s1_sel;
   logic                      s1_vld;

   // ----------------------------------------
   // Address decode
   // ----------------------------------------
   assign reg_addr = lb_addr[`RAM_SEL_BIT-1:0];
   assign ram_hit  = lb_addr[`RAM_SEL_BIT];
   assign ctrl_hit = !ram_hit && (reg_addr == `REG_CTRL);
   assign stat_hit = !ram_hit && (reg_addr == `REG_STATUS);

   // RAM read goes out in the request cycle
   assign ram_rd_req  = lb_renable && ram_hit;
   assign ram_rd_addr = lb_addr[`TRACE_AW-1:0];

   always_comb begin
      if (ram_hit) rd_sel = lb_trace_pkg::REG_SEL_RAM;
      else if (ctrl_hit) rd_sel = lb_trace_pkg::REG_SEL_CTRL;
      else if (stat_hit) rd_sel = lb_trace_pkg::REG_SEL_STATUS;
      else rd_sel = lb_trace_pkg::REG_SEL_NONE;
   end

   // ----------------------------------------
   // Control register
   // ----------------------------------------
   assign ctrl_wr = lb_valid && !lb_rnw && ctrl_hit;
   // Bit 0 self-clears, acts at the next edge
   assign rearm   = ctrl_wr && lb_wdata[0];

   always_ff @(posedge lb_clk or negedge rst_n) begin
      if (!rst_n) begin
         led_en <= 1'b0;
      end else if (ctrl_wr) begin
         led_en <= lb_wdata[1];
      end
   end

   // ----------------------------------------
   // Read pipeline
   // ----------------------------------------
   // Stage 1 tags the request, stage 2 muxes the source
   always_ff @(posedge lb_clk or negedge rst_n) begin
      if (!rst_n) begin
         s1_vld   <= 1'b0;
         s1_sel   <= lb_trace_pkg::REG_SEL_NONE;
         lb_rdata <= '0;
      end else begin
         s1_vld <= lb_renable;
         s1_sel <= rd_sel;
         // Held between results
         if (s1_vld) begin
            case (s1_sel)
               lb_trace_pkg::REG_SEL_CTRL:
                  lb_rdata <= {{(`LB_DATA_W-2){1'b0}}, led_en, 1'b0};
               lb_trace_pkg::REG_SEL_STATUS:
                  lb_rdata <= {{(`LB_DATA_W-15){1'b0}}, wr_ptr, 5'b0, overflow, cap_state};
               lb_trace_pkg::REG_SEL_RAM:
                  lb_rdata <= {{(`LB_DATA_W-`TRACE_EW){1'b0}}, ram_rdata};
               default:
                  lb_rdata <= '0;
            endcase
         end
      end
   end

   // LED 0 capture done, LED 1 overflow
   assign led = led_en ? {overflow, cap_state == lb_trace_pkg::CAP_DONE} : 2'b00;

endmodule

/* src/lb_trace_cfg.svh */
/*
 * Trace subsystem configuration
 * Bus, trace and memory sizes plus the local-bus register map
 */
`ifndef LB_TRACE_CFG_SVH
`define LB_TRACE_CFG_SVH

// Local bus from the Ethernet bridge
`define LB_ADDR_W 8
`define LB_DATA_W 32

// Run-length trace geometry
`define TRACE_DW 16
// Max run of 255 cycles
`define TRACE_TW 8
// 64 entries deep
`define TRACE_AW 6
`define TRACE_EW (`TRACE_TW + `TRACE_DW)

// Register map, word addresses below the RAM window
`define REG_CTRL 7'h00
`define REG_STATUS 7'h01
// Set selects RAM word lb_addr[5:0]
`define RAM_SEL_BIT 7

`endif

/* src/lb_trace_pkg.sv */
/*
 * Trace subsystem types
 * Capture FSM states and the read-source tag of the bus pipeline
 */
package lb_trace_pkg;

   // ----------------------------------------
   // Capture FSM
   // ----------------------------------------
   typedef enum logic [1:0] {
      // Waiting for rearm
      CAP_IDLE  = 2'd0,
      // Waiting for trace_start
      CAP_ARMED = 2'd1,
      // Sampling and compressing
      CAP_RUN   = 2'd2,
      // All entries written
      CAP_DONE  = 2'd3
   } cap_state_e;

   // ----------------------------------------
   // Read source tag, one per read in flight
   // ----------------------------------------
   typedef enum logic [1:0] {
      REG_SEL_CTRL   = 2'd0,
      REG_SEL_STATUS = 2'd1,
      REG_SEL_RAM    = 2'd2,
      // Unmapped address, reads as zero
      REG_SEL_NONE   = 2'd3
   } reg_sel_e;

endpackage

/* src/lb_trace_top.sv */
/*
 * Local-bus trace subsystem
 * Capture unit, arbiter, trace RAM and register block on lb_clk
 */
`include "lb_trace_cfg.svh"

module lb_trace_top (
   input  logic                  lb_clk,
   input  logic                  rst_n,
   input  logic                  lb_valid,
   input  logic                  lb_rnw,
   input  logic                  lb_renable,
   input  logic [`LB_ADDR_W-1:0] lb_addr,
   input  logic [`LB_DATA_W-1:0] lb_wdata,
   input  logic [`TRACE_DW-1:0]  trace_data,
   input  logic                  trace_start,
   output logic [`LB_DATA_W-1:0] lb_rdata,
   output logic [1:0]            led
);

   // Capture to arbiter
   logic                     cap_wr_req;
   logic                     cap_wr_grant;
   logic [`TRACE_AW-1:0]     cap_wr_addr;
   logic [`TRACE_EW-1:0]     cap_wr_entry;
   // Registers to arbiter
   logic                     ram_rd_req;
   logic [`TRACE_AW-1:0]     ram_rd_addr;
   // RAM port
   logic                     ram_en;
   logic                     ram_we;
   logic [`TRACE_AW-1:0]     ram_addr;
   logic [`TRACE_EW-1:0]     ram_wdata;
   logic [`TRACE_EW-1:0]     ram_rdata;
   // Capture status and control
   lb_trace_pkg::cap_state_e cap_state;
   logic [`TRACE_AW:0]       wr_ptr;
   logic                     overflow;
   logic                     rearm;

   // ----------------------------------------
   // Capture and memory
   // ----------------------------------------
   trace_capture i_trace_capture (
      .lb_clk       (lb_clk),
      .rst_n        (rst_n),
      .trace_data   (trace_data),
      .trace_start  (trace_start),
      .rearm        (rearm),
      .cap_wr_grant (cap_wr_grant),
      .cap_wr_req   (cap_wr_req),
      .cap_wr_addr  (cap_wr_addr),
      .cap_wr_entry (cap_wr_entry),
      .cap_state    (cap_state),
      .wr_ptr       (wr_ptr),
      .overflow     (overflow)
   );

   mem_arbiter i_mem_arbiter (
      .lb_clk       (lb_clk),
      .rst_n        (rst_n),
      .ram_rd_req   (ram_rd_req),
      .ram_rd_addr  (ram_rd_addr),
      .cap_wr_req   (cap_wr_req),
      .cap_wr_addr  (cap_wr_addr),
      .cap_wr_entry (cap_wr_entry),
      .cap_wr_grant (cap_wr_grant),
      .ram_en       (ram_en),
      .ram_we       (ram_we),
      .ram_addr     (ram_addr),
      .ram_wdata    (ram_wdata)
   );

   trace_ram i_trace_ram (
      .lb_clk    (lb_clk),
      .ram_en    (ram_en),
      .ram_we    (ram_we),
      .ram_addr  (ram_addr),
      .ram_wdata (ram_wdata),
      .ram_rdata (ram_rdata)
   );

   // ----------------------------------------
   // Bus side
   // ----------------------------------------
   lb_regs i_lb_regs (
      .lb_clk      (lb_clk),
      .rst_n       (rst_n),
      .lb_valid    (lb_valid),
      .lb_rnw      (lb_rnw),
      .lb_renable  (lb_renable),
      .lb_addr     (lb_addr),
      .lb_wdata    (lb_wdata),
      .ram_rdata   (ram_rdata),
      .cap_state   (cap_state),
      .wr_ptr      (wr_ptr),
      .overflow    (overflow),
      .lb_rdata    (lb_rdata),
      .ram_rd_req  (ram_rd_req),
      .ram_rd_addr (ram_rd_addr),
      .rearm       (rearm),
      .led         (led)
   );

endmodule

/* src/mem_arbiter.sv */
/*
 * Trace memory arbiter
 * Shares the single RAM port, bus reads first, capture writes otherwise
 */
`include "lb_trace_cfg.svh"

module mem_arbiter (
   input  logic                 lb_clk,
   input  logic                 rst_n,
   input  logic                 ram_rd_req,
   input  logic [`TRACE_AW-1:0] ram_rd_addr,
   input  logic                 cap_wr_req,
   input  logic [`TRACE_AW-1:0] cap_wr_addr,
   input  logic [`TRACE_EW-1:0] cap_wr_entry,
   output logic                 cap_wr_grant,
   output logic                 ram_en,
   output logic                 ram_we,
   output logic [`TRACE_AW-1:0] ram_addr,
   output logic [`TRACE_EW-1:0] ram_wdata
);

   // Cycles a pending write was held off by a read
   logic [15:0] refuse_cnt;

   // ----------------------------------------
   // Fixed priority
   // ----------------------------------------
   // Reads never wait
   assign cap_wr_grant = cap_wr_req && !ram_rd_req;

   assign ram_en    = ram_rd_req || cap_wr_grant;
   assign ram_we    = cap_wr_grant;
   assign ram_addr  = ram_rd_req ? ram_rd_addr : cap_wr_addr;
   assign ram_wdata = cap_wr_entry;

   // ----------------------------------------
   // Refusal counter
   // ----------------------------------------
   always_ff @(posedge lb_clk or negedge rst_n) begin
      if (!rst_n) begin
         refuse_cnt <= '0;
      end else if (cap_wr_req && ram_rd_req) begin
         refuse_cnt <= refuse_cnt + 1'b1;
      end
   end

endmodule

/* src/trace_capture.sv */
/*
 * Run-length trace capture
 * Packs a debug word and its hold time into entries and hands
 * each closed entry to the memory arbiter as a pending write
 */
`include "lb_trace_cfg.svh"

module trace_capture (
   input  logic                       lb_clk,
   input  logic                       rst_n,
   input  logic [`TRACE_DW-1:0]       trace_data,
   input  logic                       trace_start,
   input  logic                       rearm,
   input  logic                       cap_wr_grant,
   output logic                       cap_wr_req,
   output logic [`TRACE_AW-1:0]       cap_wr_addr,
   output logic [`TRACE_EW-1:0]       cap_wr_entry,
   output lb_trace_pkg::cap_state_e   cap_state,
   output logic [`TRACE_AW:0]         wr_ptr,
   output logic                       overflow
);

   localparam logic [`TRACE_TW-1:0] RUN_MAX = {`TRACE_TW{1'b1}};

   logic [`TRACE_DW-1:0] hold_val;
   logic [`TRACE_TW-1:0] run_cnt;
   // Entries closed so far, MSB set once memory is full
   logic [`TRACE_AW:0]   close_cnt;
   logic [`TRACE_AW:0]   wr_ptr_nxt;
   logic                 first;
   logic                 running;
   logic                 need_close;
   logic                 do_close;
   logic                 blocked;

   // ----------------------------------------
   // Compression decisions
   // ----------------------------------------
   // Start pulse takes the first sample
   assign first   = (cap_state == lb_trace_pkg::CAP_ARMED) && trace_start && !rearm;
   // Samples ignored once 64 entries have closed
   assign running = (cap_state == lb_trace_pkg::CAP_RUN) && !close_cnt[`TRACE_AW] && !rearm;

   // Value change or saturated run count
   assign need_close = running && ((trace_data != hold_val) || (run_cnt == RUN_MAX));
   // Slot is free if empty or draining this cycle
   assign do_close   = need_close && (!cap_wr_req || cap_wr_grant);
   assign blocked    = need_close && !do_close;

   assign wr_ptr_nxt = wr_ptr + 1'b1;

   // ----------------------------------------
   // Control state
   // ----------------------------------------
   always_ff @(posedge lb_clk or negedge rst_n) begin
      if (!rst_n) begin
         cap_state  <= lb_trace_pkg::CAP_IDLE;
         cap_wr_req <= 1'b0;
         close_cnt  <= '0;
         wr_ptr     <= '0;
         overflow   <= 1'b0;
      end else if (rearm) begin
         // Fresh capture, drop anything pending
         cap_state  <= lb_trace_pkg::CAP_ARMED;
         cap_wr_req <= 1'b0;
         close_cnt  <= '0;
         wr_ptr     <= '0;
         overflow   <= 1'b0;
      end else begin
         if (first) begin
            cap_state <= lb_trace_pkg::CAP_RUN;
         end
         if (cap_wr_grant) begin
            wr_ptr <= wr_ptr_nxt;
            // Last slot written
            if (wr_ptr_nxt[`TRACE_AW]) begin
               cap_state <= lb_trace_pkg::CAP_DONE;
            end
         end
         if (do_close) begin
            cap_wr_req <= 1'b1;
            close_cnt  <= close_cnt + 1'b1;
         end else if (cap_wr_grant) begin
            cap_wr_req <= 1'b0;
         end
         // Sticky until rearm
         if (blocked) begin
            overflow <= 1'b1;
         end
      end
   end

   // ----------------------------------------
   // Current run and pending entry
   // ----------------------------------------
   always_ff @(posedge lb_clk) begin
      if (first || do_close) begin
         hold_val <= trace_data;
         run_cnt  <= {{(`TRACE_TW-1){1'b0}}, 1'b1};
      end else if (running && (run_cnt != RUN_MAX)) begin
         // Also the path for a dropped change
         run_cnt <= run_cnt + 1'b1;
      end
      if (do_close) begin
         cap_wr_entry <= {run_cnt, hold_val};
         cap_wr_addr  <= close_cnt[`TRACE_AW-1:0];
      end
   end

endmodule

/* src/trace_ram.sv */
/*
 * Trace memory
 * 64 x 24 single-port RAM, registered read
 */
`include "lb_trace_cfg.svh"

module trace_ram (
   input  logic                 lb_clk,
   input  logic                 ram_en,
   input  logic                 ram_we,
   input  logic [`TRACE_AW-1:0] ram_addr,
   input  logic [`TRACE_EW-1:0] ram_wdata,
   output logic [`TRACE_EW-1:0] ram_rdata
);

   logic [`TRACE_EW-1:0] mem [0:(1 << `TRACE_AW)-1];

   // Write or read, one access per cycle
   always_ff @(posedge lb_clk) begin
      if (ram_en) begin
         if (ram_we) begin
            mem[ram_addr] <= ram_wdata;
         end else begin
            // Data one cycle after the read
            ram_rdata <= mem[ram_addr];
         end
      end
   end

endmodule

/* test/lb_trace_sva.sv */
/*
 * Trace subsystem assertions
 * RAM port sharing and capture write request rules
 */
`include "lb_trace_cfg.svh"

module lb_trace_sva (
   input logic                  lb_clk,
   input logic                  rst_n,
   input logic                  lb_renable,
   input logic [`LB_ADDR_W-1:0] lb_addr,
   input logic                  ram_rd_req,
   input logic                  ram_en,
   input logic                  ram_we,
   input logic [`TRACE_AW-1:0]  ram_addr,
   input logic                  cap_wr_req,
   input logic                  cap_wr_grant,
   input logic                  rearm,
   input logic [15:0]           refuse_cnt
);

   // Bus read of the RAM window owns the port in its cycle
   rd_no_wr: assert property (@(posedge lb_clk) disable iff (!rst_n)
      (lb_renable && lb_addr[`RAM_SEL_BIT]) |->
         (ram_en && !ram_we && ram_addr == lb_addr[`TRACE_AW-1:0]))
      else $error("RAM written or not read in a bus read cycle");

   // Pending write held until granted, rearm drops it
   req_held: assert property (@(posedge lb_clk) disable iff (!rst_n)
      (cap_wr_req && !cap_wr_grant && !rearm) |=> cap_wr_req)
      else $error("Capture write request dropped before grant");

   // Refusals only counted against a read
   refuse_grow: assert property (@(posedge lb_clk) disable iff (!rst_n)
      !ram_rd_req |=> $stable(refuse_cnt))
      else $error("Refusal count grew without a bus read");

endmodule

bind lb_trace_top lb_trace_sva i_lb_trace_sva (
   .lb_clk       (lb_clk),
   .rst_n        (rst_n),
   .lb_renable   (lb_renable),
   .lb_addr      (lb_addr),
   .ram_rd_req   (ram_rd_req),
   .ram_en       (ram_en),
   .ram_we       (ram_we),
   .ram_addr     (ram_addr),
   .cap_wr_req   (cap_wr_req),
   .cap_wr_grant (cap_wr_grant),
   .rearm        (rearm),
   .refuse_cnt   (i_mem_arbiter.refuse_cnt)
);

/* test/tb_lb_trace.sv */
/*
 * Trace subsystem testbench
 * Drives the local bus and the debug source, checks reads against
 * a run-length reference model
 */
`include "lb_trace_cfg.svh"

module tb_lb_trace;

   localparam int TIMEOUT_CYCLES = 4 * (64 * 256 + 2000);

   logic                  lb_clk;
   logic                  rst_n;
   logic                  lb_valid;
   logic                  lb_rnw;
   logic                  lb_renable;
   logic [`LB_ADDR_W-1:0] lb_addr;
   logic [`LB_DATA_W-1:0] lb_wdata;
   logic [`TRACE_DW-1:0]  trace_data;
   logic                  trace_start;
   logic [`LB_DATA_W-1:0] lb_rdata;
   logic [1:0]            led;

   int                    errors = 0;
   int                    seed = 66906;
   int                    cyc = 0;
   logic [`TRACE_DW-1:0]  rec_q[$];
   logic [`LB_DATA_W-1:0] exp_q[$];
   logic [`LB_DATA_W-1:0] mask_q[$];
   int                    due_q[$];
   // Previous capture, still in RAM while writes are held off
   logic [`TRACE_EW-1:0]  ram_snap[30];

   lb_trace_top i_dut (
      .lb_clk      (lb_clk),
      .rst_n       (rst_n),
      .lb_valid    (lb_valid),
      .lb_rnw      (lb_rnw),
      .lb_renable  (lb_renable),
      .lb_addr     (lb_addr),
      .lb_wdata    (lb_wdata),
      .trace_data  (trace_data),
      .trace_start (trace_start),
      .lb_rdata    (lb_rdata),
      .led         (led)
   );

   initial begin
      lb_clk = 1'b0;
      forever #50 lb_clk = ~lb_clk;
   end

   always @(posedge lb_clk) cyc <= cyc + 1;

   // ----------------------------------------
   // Reference model
   // ----------------------------------------
   // Entry idx of the recorded samples, run count above the value
   function automatic logic [`TRACE_EW-1:0] ref_compress(input int idx);
      logic [`TRACE_DW-1:0] val;
      int                   cnt;
      int                   n;
      int                   t;
      val = rec_q[0];
      cnt = 1;
      n = 0;
      for (t = 1; t < rec_q.size(); t++) begin
         if (rec_q[t] != val || cnt == 255) begin
            if (n == idx) return {cnt[7:0], val};
            n++;
            val = rec_q[t];
            cnt = 1;
         end else begin
            cnt++;
         end
      end
      // Entry never closed
      return '1;
   endfunction

   function automatic logic [`LB_DATA_W-1:0] status_word(input int st, input int ovf,
                                                         input int ptr);
      return (ptr << 8) | (ovf << 2) | st;
   endfunction

   // ----------------------------------------
   // Bus and trace drive
   // ----------------------------------------
   task automatic next_cycle();
      @(posedge lb_clk);
      #10;
      lb_valid    = 1'b0;
      lb_rnw      = 1'b1;
      lb_renable  = 1'b0;
      trace_start = 1'b0;
   endtask

   task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
      lb_valid = 1'b1;
      lb_rnw   = 1'b0;
      lb_addr  = addr;
      lb_wdata = data;
   endtask

   // Result due two cycles after this one
   task automatic issue_read(input logic [7:0] addr, input logic [31:0] exp,
                             input logic [31:0] mask);
      lb_renable = 1'b1;
      lb_rnw     = 1'b1;
      lb_addr    = addr;
      exp_q.push_back(exp);
      mask_q.push_back(mask);
      due_q.push_back(cyc + 2);
   endtask

   task automatic drive_sample(input logic [15:0] v);
      trace_data = v;
      rec_q.push_back(v);
   endtask

   task automatic drain_reads();
      while (exp_q.size() > 0) next_cycle();
   endtask

   task automatic rearm_and_start(input logic [15:0] v);
      next_cycle();
      bus_write(8'h00, 32'h3);
      rec_q.delete();
      next_cycle();
      trace_start = 1'b1;
      drive_sample(v);
   endtask

   task automatic random_runs_until_done();
      logic [15:0] v;
      int          h;
      while (!led[0]) begin
         v = $random(seed);
         h = 1 + {$random(seed)} % 20;
         repeat (h) begin
            next_cycle();
            drive_sample(v);
         end
      end
   endtask

   task automatic check_ram_all();
      int i;
      for (i = 0; i < 64; i++) begin
         next_cycle();
         issue_read(8'h80 | i[7:0], {8'h00, ref_compress(i)}, '1);
      end
      drain_reads();
   endtask

   task automatic check_led(input int idx, input logic exp);
      led_chk: assert (led[idx] === exp) else begin
         errors++;
         $display("[FAIL] led[%0d] expected %h actual %h", idx, exp, led[idx]);
      end
   endtask

   // ----------------------------------------
   // Read checker
   // ----------------------------------------
   initial begin
      logic [31:0] exp;
      logic [31:0] msk;
      forever begin
         @(posedge lb_clk);
         #50;
         if (due_q.size() > 0 && due_q[0] == cyc) begin
            exp = exp_q.pop_front();
            msk = mask_q.pop_front();
            void'(due_q.pop_front());
            rdata_chk: assert ((lb_rdata & msk) === (exp & msk)) else begin
               errors++;
               $display("[FAIL] lb_rdata expected %h actual %h", exp, lb_rdata);
            end
         end
      end
   end

   // Watchdog
   initial begin
      #(TIMEOUT_CYCLES * 100);
      $display("Simulation timed out after %0d clock cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
   end

   // ----------------------------------------
   // Stimulus
   // ----------------------------------------
   initial begin
      int i;
      rst_n = 1'b0;
      lb_valid = 1'b0;
      lb_rnw = 1'b1;
      lb_renable = 1'b0;
      lb_addr = '0;
      lb_wdata = '0;
      trace_data = '0;
      trace_start = 1'b0;
      repeat (10) @(posedge lb_clk);
      #10 rst_n = 1'b1;

      // Reset state
      next_cycle();
      issue_read(8'h01, status_word(0, 0, 0), '1);
      check_led(0, 1'b0);
      check_led(1, 1'b0);
      drain_reads();

      // LED enable readback, then back-to-back register reads
      next_cycle();
      bus_write(8'h00, 32'h2);
      for (i = 0; i < 4; i++) begin
         next_cycle();
         issue_read(i[0] ? 8'h01 : 8'h00, i[0] ? status_word(0, 0, 0) : 32'h2, '1);
      end
      drain_reads();

      // Random runs until all 64 entries are written
      rearm_and_start($random(seed));
      random_runs_until_done();
      next_cycle();
      issue_read(8'h01, status_word(3, 0, 64), '1);
      drain_reads();
      check_led(0, 1'b1);
      check_ram_all();

      // 600-cycle constant run, then random runs
      rearm_and_start(16'h5a5a);
      repeat (599) begin
         next_cycle();
         drive_sample(16'h5a5a);
      end
      next_cycle();
      drive_sample(16'ha5a5);
      random_runs_until_done();
      // Two saturated runs, then the 90-cycle remainder
      for (i = 0; i < 3; i++) begin
         next_cycle();
         issue_read(8'h80 | i[7:0], {8'h00, (i < 2) ? 8'd255 : 8'd90, 16'h5a5a}, '1);
      end
      drain_reads();
      check_ram_all();
      for (i = 0; i < 30; i++) begin
         ram_snap[i] = ref_compress(i);
      end

      // Back-pressure, a RAM read every cycle while data changes
      rearm_and_start(16'h0000);
      issue_read(8'h80, {8'h00, ram_snap[0]}, '1);
      for (i = 1; i < 30; i++) begin
         next_cycle();
         drive_sample(i[15:0]);
         issue_read(8'h80 | i[7:0], {8'h00, ram_snap[i]}, '1);
      end
      drain_reads();
      next_cycle();
      issue_read(8'h01, 32'h4, 32'h4);
      drain_reads();
      check_led(1, 1'b1);
      next_cycle();
      bus_write(8'h00, 32'h3);
      next_cycle();
      issue_read(8'h01, status_word(1, 0, 0), '1);
      drain_reads();
      check_led(1, 1'b0);

      repeat (5) next_cycle();
      $display("Checks done, %0d errors", errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

/* vlog.f */
+incdir+src
src/lb_trace_pkg.sv
src/trace_capture.sv
src/mem_arbiter.sv
src/trace_ram.sv
src/lb_regs.sv
src/lb_trace_top.sv
test/lb_trace_sva.sv
test/tb_lb_trace.sv
